// File: common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN 32
`define CPU_SHAMT_W 5

// RV32 major opcodes, instr[6:0]
`define CPU_OPC_OP 7'b0110011
`define CPU_OPC_OPIMM 7'b0010011
`define CPU_OPC_LUI 7'b0110111
`define CPU_OPC_AUIPC 7'b0010111
`define CPU_OPC_JAL 7'b1101111
`define CPU_OPC_JALR 7'b1100111
`define CPU_OPC_BRANCH 7'b1100011

`endif

// File: common/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef enum logic [4:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra,
		alu_slt, alu_sltu, alu_eq, alu_ne, alu_ge, alu_geu,
		alu_sh1add, alu_sh2add, alu_sh3add,
		alu_andn, alu_orn, alu_xnor,
		alu_min, alu_minu, alu_max, alu_maxu,
		alu_pass_b // result is operand two unchanged, used by lui
	} alu_op_e;

	typedef enum logic {
		opa_rs1,
		opa_pc
	} opa_sel_e;

	typedef enum logic {
		opb_rs2,
		opb_imm
	} opb_sel_e;

	typedef struct packed {
		logic [31:0] instr;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] rs1_val;
		logic [`CPU_XLEN-1:0] rs2_val;
	} exec_req_t;

	typedef struct packed {
		alu_op_e op;
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		logic [`CPU_XLEN-1:0] imm;
		logic [4:0] rd;
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		logic writes_rd; // already cleared for x0 and for illegal words
		logic illegal;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] rs1_val;
		logic [`CPU_XLEN-1:0] rs2_val;
	} exec_dec_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [`CPU_XLEN-1:0] wdata;
		logic we;
		logic taken;
		logic [`CPU_XLEN-1:0] next_pc;
		logic illegal;
	} exec_rsp_t;

endpackage

// File: alu/cpu_alu.sv
`include "cpu_consts.svh"

`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input alu_op_e i_op,

	input logic [`CPU_XLEN-1:0] i_op1,
	input logic [`CPU_XLEN-1:0] i_op2,

	output logic [`CPU_XLEN-1:0] o_result,
	output logic [`CPU_XLEN-1:0] o_shift_result,
	output logic [`CPU_XLEN-1:0] o_signed_sum_result,
	output logic o_compare_result
);

	logic [`CPU_SHAMT_W-1:0] shamt;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic [`CPU_XLEN-1:0] xor_res;
	logic [`CPU_XLEN-1:0] sh1_sum;
	logic [`CPU_XLEN-1:0] sh2_sum;
	logic [`CPU_XLEN-1:0] sh3_sum;
	logic [`CPU_XLEN-1:0] min_s;
	logic [`CPU_XLEN-1:0] min_u;
	logic [`CPU_XLEN-1:0] max_s;
	logic [`CPU_XLEN-1:0] max_u;
	logic lt_s;
	logic lt_u;
	logic eq;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// parallel datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign shamt = i_op2[`CPU_SHAMT_W-1:0];
	assign sum = i_op1 + i_op2; // signed and unsigned adds agree on 32 bits
	assign diff = i_op1 - i_op2;
	assign xor_res = i_op1 ^ i_op2;

	assign sh1_sum = (i_op1 << 1) + i_op2;
	assign sh2_sum = (i_op1 << 2) + i_op2;
	assign sh3_sum = (i_op1 << 3) + i_op2;

	assign lt_s = $signed(i_op1) < $signed(i_op2);
	assign lt_u = i_op1 < i_op2;
	assign eq = i_op1 == i_op2;

	assign min_s = lt_s ? i_op1 : i_op2; // min and max share the slt and sltu comparators
	assign min_u = lt_u ? i_op1 : i_op2;
	assign max_s = lt_s ? i_op2 : i_op1;
	assign max_u = lt_u ? i_op2 : i_op1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result groups
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (i_op)
			alu_add: o_result = sum;
			alu_sub: o_result = diff;
			alu_and: o_result = i_op1 & i_op2;
			alu_or: o_result = i_op1 | i_op2;
			alu_xor: o_result = xor_res;
			alu_sh1add: o_result = sh1_sum;
			alu_sh2add: o_result = sh2_sum;
			alu_sh3add: o_result = sh3_sum;
			alu_andn: o_result = i_op1 & ~i_op2;
			alu_orn: o_result = i_op1 | ~i_op2;
			alu_xnor: o_result = ~xor_res;
			alu_min: o_result = min_s;
			alu_minu: o_result = min_u;
			alu_max: o_result = max_s;
			alu_maxu: o_result = max_u;
			alu_pass_b: o_result = i_op2;
			default: o_result = '0;
		endcase
	end

	always_comb begin
		case (i_op)
			alu_sll: o_shift_result = i_op1 << shamt;
			alu_srl: o_shift_result = i_op1 >> shamt;
			alu_sra: o_shift_result = $signed(i_op1) >>> shamt;
			default: o_shift_result = '0;
		endcase
	end

	always_comb begin
		case (i_op)
			alu_slt: o_compare_result = lt_s;
			alu_sltu: o_compare_result = lt_u;
			alu_eq: o_compare_result = eq;
			alu_ne: o_compare_result = !eq;
			alu_ge: o_compare_result = !lt_s;
			alu_geu: o_compare_result = !lt_u;
			default: o_compare_result = 1'b0;
		endcase
	end

	assign o_signed_sum_result = sum; // jalr target before bit zero is cleared

endmodule

// File: alu/cpu_branch_unit.sv
`include "cpu_consts.svh"

`timescale 1ns/1ps

module cpu_branch_unit (
	input logic [`CPU_XLEN-1:0] i_pc,
	input logic [`CPU_XLEN-1:0] i_imm,
	input logic i_is_branch,
	input logic i_is_jal,
	input logic i_is_jalr,
	input logic i_illegal,
	input logic i_compare,
	input logic [`CPU_XLEN-1:0] i_jalr_sum,
	output logic o_taken,
	output logic [`CPU_XLEN-1:0] o_next_pc,
	output logic [`CPU_XLEN-1:0] o_link
);

	logic [`CPU_XLEN-1:0] pc_plus4;
	logic [`CPU_XLEN-1:0] rel_target;
	logic [`CPU_XLEN-1:0] jalr_target;

	assign pc_plus4 = i_pc + `CPU_XLEN'd4;
	assign rel_target = i_pc + i_imm; // shared by jal and the conditional branches
	assign jalr_target = {i_jalr_sum[`CPU_XLEN-1:1], 1'b0};

	always_comb begin
		o_taken = 1'b0;
		o_next_pc = pc_plus4; // also the fall-through for illegal words
		if (!i_illegal) begin
			if (i_is_jal) begin
				o_taken = 1'b1;
				o_next_pc = rel_target;
			end else if (i_is_jalr) begin
				o_taken = 1'b1;
				o_next_pc = jalr_target;
			end else if (i_is_branch && i_compare) begin
				o_taken = 1'b1;
				o_next_pc = rel_target;
			end
		end
	end

	assign o_link = pc_plus4;

endmodule

// File: verilog/cpu_decoder.sv
`include "cpu_consts.svh"

`timescale 1ns/1ps

module cpu_decoder import cpu_pkg::*; (
	input exec_req_t i_req,
	output exec_dec_t o_dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;
	logic [`CPU_XLEN-1:0] imm_i;
	logic [`CPU_XLEN-1:0] imm_b;
	logic [`CPU_XLEN-1:0] imm_u;
	logic [`CPU_XLEN-1:0] imm_j;
	logic legal;

	assign opcode = i_req.instr[6:0];
	assign rd = i_req.instr[11:7];
	assign funct3 = i_req.instr[14:12];
	assign funct7 = i_req.instr[31:25];

	assign imm_i = {{20{i_req.instr[31]}}, i_req.instr[31:20]};
	assign imm_b = {{19{i_req.instr[31]}}, i_req.instr[31], i_req.instr[7],
		i_req.instr[30:25], i_req.instr[11:8], 1'b0};
	assign imm_u = {i_req.instr[31:12], 12'b0};
	assign imm_j = {{11{i_req.instr[31]}}, i_req.instr[31], i_req.instr[19:12],
		i_req.instr[20], i_req.instr[30:21], 1'b0};

	always_comb begin
		o_dec = '0;
		o_dec.op = alu_add;
		o_dec.opa_sel = opa_rs1;
		o_dec.opb_sel = opb_rs2;
		legal = 1'b1;
		case (opcode)
			`CPU_OPC_OP: begin
				case ({funct7, funct3})
					10'b0000000_000: o_dec.op = alu_add;
					10'b0000000_001: o_dec.op = alu_sll;
					10'b0000000_010: o_dec.op = alu_slt;
					10'b0000000_011: o_dec.op = alu_sltu;
					10'b0000000_100: o_dec.op = alu_xor;
					10'b0000000_101: o_dec.op = alu_srl;
					10'b0000000_110: o_dec.op = alu_or;
					10'b0000000_111: o_dec.op = alu_and;
					10'b0100000_000: o_dec.op = alu_sub;
					10'b0100000_101: o_dec.op = alu_sra;
					10'b0100000_111: o_dec.op = alu_andn; // Zbb reuses the sub/sra funct7
					10'b0100000_110: o_dec.op = alu_orn;
					10'b0100000_100: o_dec.op = alu_xnor;
					10'b0010000_010: o_dec.op = alu_sh1add;
					10'b0010000_100: o_dec.op = alu_sh2add;
					10'b0010000_110: o_dec.op = alu_sh3add;
					10'b0000101_100: o_dec.op = alu_min;
					10'b0000101_101: o_dec.op = alu_minu;
					10'b0000101_110: o_dec.op = alu_max;
					10'b0000101_111: o_dec.op = alu_maxu;
					default: legal = 1'b0;
				endcase
			end
			`CPU_OPC_OPIMM: begin
				o_dec.opb_sel = opb_imm;
				o_dec.imm = imm_i;
				case (funct3)
					3'b000: o_dec.op = alu_add;
					3'b010: o_dec.op = alu_slt;
					3'b011: o_dec.op = alu_sltu;
					3'b100: o_dec.op = alu_xor;
					3'b110: o_dec.op = alu_or;
					3'b111: o_dec.op = alu_and;
					3'b001: begin
						o_dec.op = alu_sll;
						legal = funct7 == 7'b0000000;
					end
					default: begin // funct3 101, srli or srai by funct7
						o_dec.op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
						legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
				endcase
			end
			`CPU_OPC_LUI: begin
				o_dec.op = alu_pass_b;
				o_dec.opb_sel = opb_imm;
				o_dec.imm = imm_u;
			end
			`CPU_OPC_AUIPC: begin
				o_dec.opa_sel = opa_pc;
				o_dec.opb_sel = opb_imm;
				o_dec.imm = imm_u;
			end
			`CPU_OPC_JAL: begin
				o_dec.opa_sel = opa_pc;
				o_dec.opb_sel = opb_imm;
				o_dec.imm = imm_j;
				o_dec.is_jal = 1'b1;
			end
			`CPU_OPC_JALR: begin
				o_dec.opb_sel = opb_imm; // alu adds rs1 and imm for the target
				o_dec.imm = imm_i;
				o_dec.is_jalr = 1'b1;
				legal = funct3 == 3'b000;
			end
			`CPU_OPC_BRANCH: begin
				o_dec.imm = imm_b;
				o_dec.is_branch = 1'b1;
				case (funct3)
					3'b000: o_dec.op = alu_eq;
					3'b001: o_dec.op = alu_ne;
					3'b100: o_dec.op = alu_slt;
					3'b101: o_dec.op = alu_ge;
					3'b110: o_dec.op = alu_sltu;
					3'b111: o_dec.op = alu_geu;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase

		o_dec.rd = rd;
		o_dec.illegal = !legal;
		o_dec.writes_rd = legal && !o_dec.is_branch && (rd != 5'd0);
		o_dec.pc = i_req.pc;
		o_dec.rs1_val = i_req.rs1_val;
		o_dec.rs2_val = i_req.rs2_val;
	end

endmodule

// File: verilog/cpu_stage_reg.sv
`timescale 1ns/1ps

module cpu_stage_reg #(
	parameter type payload_t = logic
) (
	input logic i_clk,
	input logic i_rst,

	input payload_t i_data,
	input logic i_valid,
	output logic o_ready,

	output payload_t o_data,
	output logic o_valid,
	input logic i_ready
);

	// take a new entry when empty or when the current one leaves this cycle
	assign o_ready = !o_valid || i_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else if (o_ready) begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ready && i_valid) begin
			o_data <= i_data; // payload holds still while stalled
		end
	end

endmodule

// File: verilog/cpu_execute.sv
`include "cpu_consts.svh"

`timescale 1ns/1ps

module cpu_execute import cpu_pkg::*; (
	input logic i_clk,
	input logic i_rst,

	input exec_req_t i_req,
	input logic i_req_valid,
	output logic o_req_ready,

	output exec_rsp_t o_rsp,
	output logic o_rsp_valid,
	input logic i_rsp_ready
);

	exec_dec_t dec_d;
	exec_dec_t dec_q;
	logic dec_valid;
	logic rsp_stage_ready;
	exec_rsp_t rsp_d;
	logic [`CPU_XLEN-1:0] op1;
	logic [`CPU_XLEN-1:0] op2;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] shift_result;
	logic [`CPU_XLEN-1:0] signed_sum;
	logic compare;
	logic taken;
	logic [`CPU_XLEN-1:0] next_pc;
	logic [`CPU_XLEN-1:0] link;
	logic [`CPU_XLEN-1:0] wdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage one, decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	cpu_decoder cpu_decoder_inst (
		.i_req(i_req),
		.o_dec(dec_d)
	);

	cpu_stage_reg #(.payload_t(exec_dec_t)) dec_stage_inst (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_data(dec_d),
		.i_valid(i_req_valid),
		.o_ready(o_req_ready),
		.o_data(dec_q),
		.o_valid(dec_valid),
		.i_ready(rsp_stage_ready)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage two, execute and writeback
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign op1 = (dec_q.opa_sel == opa_pc) ? dec_q.pc : dec_q.rs1_val;
	assign op2 = (dec_q.opb_sel == opb_imm) ? dec_q.imm : dec_q.rs2_val;

	cpu_alu cpu_alu_inst (
		.i_op(dec_q.op),
		.i_op1(op1),
		.i_op2(op2),
		.o_result(alu_result),
		.o_shift_result(shift_result),
		.o_signed_sum_result(signed_sum),
		.o_compare_result(compare)
	);

	cpu_branch_unit cpu_branch_unit_inst (
		.i_pc(dec_q.pc),
		.i_imm(dec_q.imm),
		.i_is_branch(dec_q.is_branch),
		.i_is_jal(dec_q.is_jal),
		.i_is_jalr(dec_q.is_jalr),
		.i_illegal(dec_q.illegal),
		.i_compare(compare),
		.i_jalr_sum(signed_sum),
		.o_taken(taken),
		.o_next_pc(next_pc),
		.o_link(link)
	);

	always_comb begin
		if (dec_q.is_jal || dec_q.is_jalr) begin
			wdata = link; // jumps write back pc plus 4
		end else begin
			case (dec_q.op)
				alu_slt, alu_sltu: wdata = {{(`CPU_XLEN-1){1'b0}}, compare};
				alu_sll, alu_srl, alu_sra: wdata = shift_result;
				default: wdata = alu_result;
			endcase
		end
	end

	assign rsp_d.rd = dec_q.rd;
	assign rsp_d.wdata = wdata;
	assign rsp_d.we = dec_q.writes_rd;
	assign rsp_d.taken = taken;
	assign rsp_d.next_pc = next_pc;
	assign rsp_d.illegal = dec_q.illegal;

	cpu_stage_reg #(.payload_t(exec_rsp_t)) rsp_stage_inst (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_data(rsp_d),
		.i_valid(dec_valid),
		.o_ready(rsp_stage_ready),
		.o_data(o_rsp),
		.o_valid(o_rsp_valid),
		.i_ready(i_rsp_ready)
	);

endmodule

// File: test/tb_cpu_execute.sv
`include "cpu_consts.svh"

`timescale 1ns/1ps

module tb_cpu_execute import cpu_pkg::*; ();

	localparam int timeout_cycles = 200;
	localparam int first_rsp_latency = 1; // edges from request acceptance until o_rsp_valid

	logic clk;
	logic rst;
	exec_req_t req;
	logic req_valid;
	logic req_ready;
	exec_rsp_t rsp;
	logic rsp_valid;
	logic rsp_ready;

	exec_req_t req_q[$];
	exec_rsp_t exp_q[$];
	integer seed = 27;
	int cycle_cnt = 0;
	int accept_cycle = 0;
	bit first_rsp_seen = 1'b0;
	bit all_done = 1'b0;

	cpu_execute cpu_execute_inst (
		.i_clk(clk),
		.i_rst(rst),
		.i_req(req),
		.i_req_valid(req_valid),
		.o_req_ready(req_ready),
		.o_rsp(rsp),
		.o_rsp_valid(rsp_valid),
		.i_rsp_ready(rsp_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// response checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_writeback(input exec_rsp_t got, input exec_rsp_t exp, input int idx);
		if (got.we !== exp.we) begin
			abort_run($sformatf("mismatch we got %h expected %h in response %0d",
				got.we, exp.we, idx));
		end
		if (exp.we) begin // rd and wdata only matter when the write is enabled
			if (got.rd !== exp.rd) begin
				abort_run($sformatf("mismatch rd got %h expected %h in response %0d",
					got.rd, exp.rd, idx));
			end
			if (got.wdata !== exp.wdata) begin
				abort_run($sformatf("mismatch wdata got %h expected %h in response %0d",
					got.wdata, exp.wdata, idx));
			end
		end
	endtask

	task automatic check_flow(input exec_rsp_t got, input exec_rsp_t exp, input int idx);
		if (got.taken !== exp.taken) begin
			abort_run($sformatf("mismatch taken got %h expected %h in response %0d",
				got.taken, exp.taken, idx));
		end
		if (got.next_pc !== exp.next_pc) begin
			abort_run($sformatf("mismatch next_pc got %h expected %h in response %0d",
				got.next_pc, exp.next_pc, idx));
		end
		if (got.illegal !== exp.illegal) begin
			abort_run($sformatf("mismatch illegal got %h expected %h in response %0d",
				got.illegal, exp.illegal, idx));
		end
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int n_branch;
		string line;
		logic [31:0] instr;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] rs1;
		logic [`CPU_XLEN-1:0] rs2;
		logic [`CPU_XLEN-1:0] wdata;
		logic [`CPU_XLEN-1:0] npc;
		logic [4:0] rd;
		logic we;
		logic taken;
		logic illegal;
		exec_req_t item;
		exec_rsp_t exp;
		n_branch = 0;
		fd = $fopen("test/exec_cases.txt", "r");
		if (fd == 0) begin
			abort_run("could not open test/exec_cases.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "/") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
					instr, pc, rs1, rs2, rd, wdata, we, taken, npc, illegal);
				if (n != 10) begin
					abort_run("malformed line in test/exec_cases.txt");
				end
				item = '{instr: instr, pc: pc, rs1_val: rs1, rs2_val: rs2};
				exp = '{rd: rd, wdata: wdata, we: we, taken: taken, next_pc: npc,
					illegal: illegal};
				req_q.push_back(item);
				exp_q.push_back(exp);
				if (instr[6:0] == `CPU_OPC_BRANCH) begin
					n_branch++;
				end
			end
		end
		$fclose(fd);
		$display("loaded %0d instructions, %0d of them branches", req_q.size(), n_branch);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stream processes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_request(input exec_req_t item, input bit first);
		int waited;
		waited = 0;
		req = item;
		req_valid = 1'b1;
		@(negedge clk);
		while (!req_ready) begin
			waited++;
			if (waited > timeout_cycles) begin
				abort_run("o_req_ready never came back high");
			end
			@(negedge clk);
		end
		@(posedge clk); // the request transfers on this edge
		#1;
		if (first) begin
			accept_cycle = cycle_cnt;
		end
	endtask

	task automatic drive_all();
		for (int i = 0; i < req_q.size(); i++) begin
			send_request(req_q[i], i == 0);
		end
		req_valid = 1'b0;
	endtask

	task automatic collect_all();
		int waited;
		int total;
		exec_rsp_t exp;
		total = exp_q.size();
		for (int i = 0; i < total; i++) begin
			waited = 0;
			@(negedge clk);
			while (!(rsp_valid && rsp_ready)) begin
				waited++;
				if (waited > timeout_cycles) begin
					abort_run($sformatf("o_rsp_valid never came for response %0d", i));
				end
				@(negedge clk);
			end
			if (i == 0 && cycle_cnt != accept_cycle + first_rsp_latency) begin
				abort_run($sformatf("first response seen at edge %0d, request accepted at %0d",
					cycle_cnt, accept_cycle));
			end
			exp = exp_q.pop_front();
			check_writeback(rsp, exp, i);
			check_flow(rsp, exp, i);
			first_rsp_seen = 1'b1;
		end
		all_done = 1'b1;
	endtask

	task automatic throttle_ready();
		int waited;
		int limit;
		waited = 0;
		limit = timeout_cycles * (req_q.size() + 1);
		while (!first_rsp_seen) begin // ready stays high until the latency check is done
			@(posedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				abort_run("no response arrived before back-pressure could start");
			end
		end
		waited = 0;
		while (!all_done) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > limit) begin
				abort_run("responses were still missing when back-pressure timed out");
			end
			rsp_ready = ($random(seed) % 4) != 0; // ready about three cycles in four
		end
		rsp_ready = 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b1;
		load_cases();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (rsp_valid !== 1'b0) begin
			abort_run("o_rsp_valid is not low after reset");
		end
		if (req_ready !== 1'b1) begin
			abort_run("o_req_ready is not high after reset");
		end
		@(posedge clk);
		#1;
		fork
			drive_all();
			collect_all();
			throttle_ready();
		join
		repeat (4) begin
			@(negedge clk);
			if (rsp_valid) begin
				abort_run("a response arrived with no request left");
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: test/exec_cases.txt
// instr pc rs1_val rs2_val then expected rd wdata we taken next_pc illegal, all hex
// rd and wdata are checked only on lines with we set
002082B3 00001000 00000005 00000003 05 00000008 1 0 00001004 0
402082B3 00001000 00000003 00000005 05 FFFFFFFE 1 0 00001004 0
002092B3 00001000 00000003 00000021 05 00000006 1 0 00001004 0
0020A2B3 00001000 80000000 00000001 05 00000001 1 0 00001004 0
0020B2B3 00001000 80000000 00000001 05 00000000 1 0 00001004 0
0020C2B3 00001000 F0F0F0F0 FF00FF00 05 0FF00FF0 1 0 00001004 0
0020D2B3 00001000 80000000 00000004 05 08000000 1 0 00001004 0
4020D2B3 00001000 80000000 00000004 05 F8000000 1 0 00001004 0
0020F2B3 00001000 F0F0F0F0 FF00FF00 05 F000F000 1 0 00001004 0
FFF08293 00001000 00000010 00000000 05 0000000F 1 0 00001004 0
0010A293 00001000 FFFFFFFF 00000000 05 00000001 1 0 00001004 0
8000E293 00001000 00000001 00000000 05 FFFFF801 1 0 00001004 0
0F00F293 00001000 12345678 00000000 05 00000070 1 0 00001004 0
00809293 00001000 000000AB 00000000 05 0000AB00 1 0 00001004 0
4040D293 00001000 F0000000 00000000 05 FF000000 1 0 00001004 0
2020A2B3 00001000 00000003 00000010 05 00000016 1 0 00001004 0
2020E2B3 00001000 00000003 00000010 05 00000028 1 0 00001004 0
4020F2B3 00001000 FF00FF00 0F0F0F0F 05 F000F000 1 0 00001004 0
4020C2B3 00001000 F0F0F0F0 FF00FF00 05 F00FF00F 1 0 00001004 0
0A20C2B3 00001000 80000000 00000001 05 80000000 1 0 00001004 0
0A20D2B3 00001000 80000000 00000001 05 00000001 1 0 00001004 0
0A20E2B3 00001000 80000000 00000001 05 00000001 1 0 00001004 0
0A20F2B3 00001000 80000000 00000001 05 80000000 1 0 00001004 0
00208863 00002000 00000007 00000007 00 00000000 0 1 00002010 0
FE209CE3 00002000 00000001 00000002 00 00000000 0 1 00001FF8 0
0020C863 00002000 80000000 00000001 00 00000000 0 1 00002010 0
0020D863 00002000 80000000 00000001 00 00000000 0 0 00002004 0
0020E863 00002000 80000000 00000001 00 00000000 0 0 00002004 0
0020F863 00002000 80000000 00000001 00 00000000 0 1 00002010 0
100000EF 00003000 00000000 00000000 01 00003004 1 1 00003100 0
003280E7 00003000 00004000 00000000 01 00003004 1 1 00004002 0
123452B7 00004000 00000000 00000000 05 12345000 1 0 00004004 0
00001297 00005000 00000000 00000000 05 00006000 1 0 00005004 0
00208033 00001000 00000005 00000003 00 00000000 0 0 00001004 0
FFFFFFFF 00006000 00000000 00000000 00 00000000 0 0 00006004 1
7E0082B3 00006000 00000001 00000002 00 00000000 0 0 00006004 1

// File: build.f
+incdir+common
common/cpu_pkg.sv
alu/cpu_alu.sv
alu/cpu_branch_unit.sv
verilog/cpu_decoder.sv
verilog/cpu_stage_reg.sv
verilog/cpu_execute.sv
test/tb_cpu_execute.sv

// File: Bender.yml
package:
  name: cpu_execute

export_include_dirs:
  - common

sources:
  - common/cpu_pkg.sv
  - alu/cpu_alu.sv
  - alu/cpu_branch_unit.sv
  - verilog/cpu_decoder.sv
  - verilog/cpu_stage_reg.sv
  - verilog/cpu_execute.sv
  - target: test
    files:
      - test/tb_cpu_execute.sv
